//--- logic/rv_pkg.sv
// rv32 core shared types
package rv_pkg;

	// ----------------------------------------
	// widths

	localparam int xlen = 32;

	// data or instruction word
	typedef logic [xlen-1:0] word_t;

	// byte address without the two low bits
	typedef logic [xlen-3:0] word_addr_t;

	typedef logic [4:0] reg_idx_t;

	// ----------------------------------------
	// encodings

	// major opcodes in use
	typedef enum logic [6:0] {
		op_rtype  = 7'b0110011,
		op_itype  = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_slt = 4'd4
	} alu_op_t;

	// operand source, newest producer wins
	typedef enum logic [1:0] {
		fwd_none = 2'd0,
		fwd_wb   = 2'd1,
		fwd_mem  = 2'd2
	} fwd_sel_t;

	// ----------------------------------------
	// constants

	localparam reg_idx_t reg_zero = 5'd0;

	// opcode 0 decodes as a bubble
	localparam word_t nop_word = '0;

endpackage

//--- logic/rv_decode.sv
// instruction decoder
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input  word_t    instr,
	input  word_t    pc,
	output logic     reg_write,
	output logic     mem_read,
	output logic     mem_write,
	output logic     mem_to_reg,
	output logic     alu_src,
	output logic     branch,
	output logic     branch_ne,
	output logic     jal,
	output logic     jalr,
	output alu_op_t  alu_op,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output word_t    imm
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic       alt;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;

	// arithmetic op from funct3, sub only for register forms
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic use_sub);
		case (f3)
			3'b111:  return alu_and;
			3'b110:  return alu_or;
			3'b010:  return alu_slt;
			default: return use_sub ? alu_sub : alu_add;
		endcase
	endfunction

	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign alt    = instr[30];
	assign rd     = instr[11:7];

	// ----------------------------------------
	// immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// ----------------------------------------
	// control
	always_comb begin
		reg_write  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		alu_src    = 1'b0;
		branch     = 1'b0;
		branch_ne  = 1'b0;
		jal        = 1'b0;
		jalr       = 1'b0;
		alu_op     = alu_add;
		imm        = '0;
		// unused source fields read x0, no false hazards
		rs1        = reg_zero;
		rs2        = reg_zero;
		case (opcode)
			op_rtype: begin
				reg_write = 1'b1;
				alu_op    = arith_op(funct3, alt);
				rs1       = instr[19:15];
				rs2       = instr[24:20];
			end
			op_itype: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
				alu_op    = arith_op(funct3, 1'b0);
				imm       = imm_i;
				rs1       = instr[19:15];
			end
			op_load: begin
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
				alu_src    = 1'b1;
				imm        = imm_i;
				rs1        = instr[19:15];
			end
			op_store: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
				imm       = imm_s;
				rs1       = instr[19:15];
				rs2       = instr[24:20];
			end
			op_branch: begin
				branch    = 1'b1;
				// funct3 bit 0 tells bne from beq
				branch_ne = funct3[0];
				alu_op    = alu_sub;
				imm       = imm_b;
				rs1       = instr[19:15];
				rs2       = instr[24:20];
			end
			op_jal: begin
				reg_write = 1'b1;
				jal       = 1'b1;
				imm       = imm_j;
			end
			op_jalr: begin
				reg_write = 1'b1;
				jalr      = 1'b1;
				alu_src   = 1'b1;
				imm       = imm_i;
				rs1       = instr[19:15];
			end
			default: ;
		endcase
	end

	// jump targets computed upstream must land on a word
	always_comb begin
		if (jal || jalr || branch) begin
			assert (pc[1:0] == 2'b00) else $error("decode: control flow at odd pc %h", pc);
		end
	end

endmodule

//--- logic/rv_regfile.sv
// integer register file
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  word_t    rd_data,
	input  logic     we,
	output word_t    rs1_data,
	output word_t    rs2_data
);

	word_t regs [32];
	logic  wr_live;

	// x0 is never written so it reads zero
	assign wr_live = we && (rd != reg_zero);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_live) begin
			regs[rd] <= rd_data;
		end
	end

	// write port bypass, same-cycle read sees new value
	assign rs1_data = (wr_live && rd == rs1) ? rd_data : regs[rs1];
	assign rs2_data = (wr_live && rd == rs2) ? rd_data : regs[rs2];

endmodule

//--- logic/rv_alu.sv
// integer alu
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    zero
);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			// signed compare
			alu_slt: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

	// beq and bne look at this after a subtract
	assign zero = (result == '0);

endmodule

//--- logic/rv_hazard.sv
// forwarding and interlock unit
`timescale 1ns/1ps

module rv_hazard import rv_pkg::*; (
	input  reg_idx_t id_rs1,
	input  reg_idx_t id_rs2,
	input  logic     id_jalr,
	input  reg_idx_t ex_rs1,
	input  reg_idx_t ex_rs2,
	input  reg_idx_t ex_rd,
	input  logic     ex_reg_write,
	input  logic     ex_mem_read,
	input  logic     ex_branch_taken,
	input  reg_idx_t mem_rd,
	input  logic     mem_reg_write,
	input  reg_idx_t wb_rd,
	input  logic     wb_reg_write,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output fwd_sel_t jalr_fwd,
	output logic     load_use_stall,
	output logic     flush_id
);

	logic ex_hit_rs1;
	logic ex_hit_rs2;

	// newest in-flight producer of a register
	function automatic fwd_sel_t newest(
		input reg_idx_t src,
		input reg_idx_t m_rd,
		input logic     m_we,
		input reg_idx_t w_rd,
		input logic     w_we
	);
		if (src == reg_zero) return fwd_none;
		if (m_we && m_rd == src) return fwd_mem;
		if (w_we && w_rd == src) return fwd_wb;
		return fwd_none;
	endfunction

	// ----------------------------------------
	// forwarding
	always_comb begin
		fwd_a    = newest(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
		fwd_b    = newest(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
		jalr_fwd = id_jalr ? newest(id_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write)
			: fwd_none;
	end

	// ----------------------------------------
	// interlock and flush
	assign ex_hit_rs1 = (ex_rd != reg_zero) && (ex_rd == id_rs1);
	assign ex_hit_rs2 = (ex_rd != reg_zero) && (ex_rd == id_rs2);

	// load result not ready yet; jalr base from execute has no path either
	assign load_use_stall = (ex_mem_read && (ex_hit_rs1 || ex_hit_rs2))
		|| (id_jalr && ex_reg_write && ex_hit_rs1);

	assign flush_id = ex_branch_taken;

	// a branch in execute writes no register, so it never interlocks
	always_comb begin
		assert (!(load_use_stall && flush_id))
			else $error("hazard: interlock and branch flush together");
	end

endmodule

//--- logic/rv_core.sv
// five-stage rv32 pipeline
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	output word_addr_t imem_addr,
	input  word_t      imem_rdata,
	input  logic       imem_stall,
	output logic       dmem_read,
	output logic       dmem_write,
	output word_addr_t dmem_addr,
	output word_t      dmem_wdata,
	input  word_t      dmem_rdata,
	input  logic       dmem_stall
);

	logic     freeze;
	word_t    pc, pc_next;
	word_t    id_instr, id_pc, id_imm, id_rs1_data, id_rs2_data;
	word_t    jalr_base, jalr_sum, jump_target;
	logic     id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg, id_alu_src;
	logic     id_branch, id_branch_ne, id_jal, id_jalr, id_redirect, id_kill;
	alu_op_t  id_alu_op;
	reg_idx_t id_rs1, id_rs2, id_rd;
	logic     ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_alu_src;
	logic     ex_branch, ex_branch_ne, ex_jal, ex_jalr, ex_branch_taken, alu_zero;
	alu_op_t  ex_alu_op;
	reg_idx_t ex_rs1, ex_rs2, ex_rd;
	word_t    ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
	word_t    ex_src_a, ex_src_b, alu_b, alu_result, ex_result;
	logic     mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg;
	reg_idx_t mem_rd;
	word_t    mem_result, mem_store_data, load_data, mem_fwd_value;
	logic     wb_reg_write, wb_mem_to_reg;
	reg_idx_t wb_rd;
	word_t    wb_result, wb_load_data, wb_value;
	fwd_sel_t fwd_a, fwd_b, jalr_fwd;
	logic     load_use_stall, flush_id;

	// memory side is big-endian
	function automatic word_t swap_bytes(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic word_t pick_src(input fwd_sel_t sel, input word_t own,
		input word_t from_mem, input word_t from_wb);
		case (sel)
			fwd_mem: return from_mem;
			fwd_wb:  return from_wb;
			default: return own;
		endcase
	endfunction

	// either memory stalling freezes every stage
	assign freeze = imem_stall || dmem_stall;

	// ----------------------------------------
	// fetch
	assign imem_addr = pc[xlen-1:2];

	always_comb begin
		if (flush_id) pc_next = ex_pc + ex_imm;
		else if (load_use_stall) pc_next = pc;
		else if (id_jal || id_jalr) pc_next = jump_target;
		else pc_next = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!freeze) begin
			pc <= pc_next;
		end
	end

	// fetched word dropped on any redirect
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_instr <= nop_word;
		end else if (!freeze) begin
			if (flush_id || id_redirect) id_instr <= nop_word;
			else if (!load_use_stall) id_instr <= swap_bytes(imem_rdata);
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze && !load_use_stall) id_pc <= pc;
	end

	// ----------------------------------------
	// decode
	rv_decode i_decode (
		.instr(id_instr), .pc(id_pc), .reg_write(id_reg_write), .mem_read(id_mem_read),
		.mem_write(id_mem_write), .mem_to_reg(id_mem_to_reg), .alu_src(id_alu_src),
		.branch(id_branch), .branch_ne(id_branch_ne), .jal(id_jal), .jalr(id_jalr),
		.alu_op(id_alu_op), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm)
	);

	rv_regfile i_regfile (
		.clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
		.rd_data(wb_value), .we(wb_reg_write), .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
	);

	// jalr base may come from memory or write-back
	assign jalr_base   = pick_src(jalr_fwd, id_rs1_data, mem_fwd_value, wb_value);
	assign jalr_sum    = jalr_base + id_imm;
	assign jump_target = id_jal ? id_pc + id_imm : {jalr_sum[xlen-1:1], 1'b0};
	assign id_redirect = (id_jal || id_jalr) && !load_use_stall;
	assign id_kill     = flush_id || load_use_stall;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg} <= '0;
			{ex_alu_src, ex_branch, ex_branch_ne, ex_jal, ex_jalr} <= '0;
			ex_alu_op <= alu_add;
			{ex_rs1, ex_rs2, ex_rd} <= {3{reg_zero}};
		end else if (!freeze) begin
			ex_reg_write  <= id_reg_write && !id_kill;
			ex_mem_read   <= id_mem_read && !id_kill;
			ex_mem_write  <= id_mem_write && !id_kill;
			ex_mem_to_reg <= id_mem_to_reg;
			ex_alu_src    <= id_alu_src;
			ex_branch     <= id_branch && !id_kill;
			ex_branch_ne  <= id_branch_ne;
			ex_jal        <= id_jal && !id_kill;
			ex_jalr       <= id_jalr && !id_kill;
			ex_alu_op     <= id_alu_op;
			ex_rs1        <= id_rs1;
			ex_rs2        <= id_rs2;
			ex_rd         <= id_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			ex_pc       <= id_pc;
			ex_imm      <= id_imm;
			ex_rs1_data <= id_rs1_data;
			ex_rs2_data <= id_rs2_data;
		end
	end

	// ----------------------------------------
	// execute
	assign ex_src_a = pick_src(fwd_a, ex_rs1_data, mem_fwd_value, wb_value);
	assign ex_src_b = pick_src(fwd_b, ex_rs2_data, mem_fwd_value, wb_value);
	assign alu_b    = ex_alu_src ? ex_imm : ex_src_b;

	rv_alu i_alu (.op(ex_alu_op), .a(ex_src_a), .b(alu_b), .result(alu_result), .zero(alu_zero));

	// jumps write back their link address
	assign ex_result       = (ex_jal || ex_jalr) ? ex_pc + 32'd4 : alu_result;
	assign ex_branch_taken = ex_branch && (ex_branch_ne ^ alu_zero);

	rv_hazard i_hazard (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .id_jalr(id_jalr), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
		.ex_branch_taken(ex_branch_taken), .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
		.wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.jalr_fwd(jalr_fwd), .load_use_stall(load_use_stall), .flush_id(flush_id)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg} <= '0;
			mem_rd <= reg_zero;
		end else if (!freeze) begin
			{mem_reg_write, mem_mem_read} <= {ex_reg_write, ex_mem_read};
			{mem_mem_write, mem_mem_to_reg} <= {ex_mem_write, ex_mem_to_reg};
			mem_rd <= ex_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			mem_result     <= ex_result;
			mem_store_data <= ex_src_b;
		end
	end

	// ----------------------------------------
	// memory access
	assign dmem_read     = mem_mem_read;
	assign dmem_write    = mem_mem_write;
	assign dmem_addr     = mem_result[xlen-1:2];
	assign dmem_wdata    = swap_bytes(mem_store_data);
	assign load_data     = swap_bytes(dmem_rdata);
	assign mem_fwd_value = mem_mem_to_reg ? load_data : mem_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{wb_reg_write, wb_mem_to_reg} <= '0;
			wb_rd <= reg_zero;
		end else if (!freeze) begin
			{wb_reg_write, wb_mem_to_reg} <= {mem_reg_write, mem_mem_to_reg};
			wb_rd <= mem_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wb_result    <= mem_result;
			wb_load_data <= load_data;
		end
	end

	assign wb_value = wb_mem_to_reg ? wb_load_data : wb_result;

	// ----------------------------------------
	// port checks
	assert property (@(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write))
		else $error("core: load and store requested together");

	assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_read || dmem_write) && dmem_stall
		|=> $stable({dmem_read, dmem_write, dmem_addr, dmem_wdata}))
		else $error("core: data request changed under stall");

endmodule

//--- test/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	input  logic restart,
	output logic clk,
	output logic rst_n
);

	int unsigned hold = 5;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset stays low for five rising edges
	always @(posedge clk) begin
		if (restart) begin
			hold <= 5;
		end else if (hold != 0) begin
			hold <= hold - 1;
		end
	end

	assign rst_n = (hold == 0);

endmodule

//--- test/tb_top.sv
// pipeline core testbench
`timescale 1ns/1ps

module tb_top import rv_pkg::*; ();

	localparam int cycles_per_phase = 400;
	localparam int phase_count = 3;
	localparam int opc_imm = 'h13;
	localparam int opc_load = 'h03;
	localparam int opc_jalr = 'h67;
	localparam word_t done_addr = 32'h130;
	localparam word_t bad_base = 32'h1e0;
	localparam word_t poison = 32'hdead_beef;

	logic       clk, rst_n;
	logic       restart = 1'b0;
	logic       imem_stall = 1'b0;
	logic       dmem_stall = 1'b0;
	logic       dmem_read, dmem_write;
	word_addr_t imem_addr, dmem_addr;
	word_t      imem_rdata, dmem_rdata, dmem_wdata, dmem_byte_addr;
	word_t      imem [64];
	word_t      dmem [128];
	word_t      log_addr[$], log_data[$], exp_addr[$], exp_data[$];
	int         seed = 47;
	int         phase = 0;
	int         cycles = 0;
	int         prog_len = 0;
	int         port_errs = 0;
	int         log_errs = 0;
	int         store_errs = 0;
	logic       finished = 1'b0;
	logic       prev_rst_low = 1'b0;
	logic       prev_hold = 1'b0;
	logic [63:0] prev_req;

	tb_clock i_clock (.restart(restart), .clk(clk), .rst_n(rst_n));

	rv_core i_dut (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.imem_stall(imem_stall), .dmem_read(dmem_read), .dmem_write(dmem_write),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
		.dmem_stall(dmem_stall)
	);

	// ----------------------------------------
	// encoding and memory helpers

	function automatic word_t r_form(input int f7, f3, rd, rs1, rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t i_form(input int op, f3, rd, rs1, imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic word_t s_form(input int rs2, rs1, imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_form(input int f3, rs1, rs2, imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t j_form(input int rd, imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic word_t byte_reverse(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// every word differs, mixes in all index bits
	function automatic word_t fill_word(input int idx);
		return word_t'(idx) * 32'h9e37_79b1 ^ 32'h5a5a_a5a5;
	endfunction

	task automatic place(input word_t w);
		imem[prog_len[5:0]] = w;
		prog_len++;
	endtask

	task automatic add_expected(input word_t a, input word_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	// ----------------------------------------
	// memory models, stall source, store log

	assign imem_rdata     = imem_stall ? poison : byte_reverse(imem[imem_addr[5:0]]);
	assign dmem_rdata     = dmem_stall ? poison : byte_reverse(dmem[dmem_addr[6:0]]);
	assign dmem_byte_addr = {dmem_addr, 2'b00};

	always @(posedge clk) begin
		imem_stall <= (phase == 1) && (($random(seed) & 3) < 2);
		dmem_stall <= (phase == 2) && (($random(seed) & 3) < 2);
	end

	always @(posedge clk) begin
		if (restart) begin
			for (int i = 0; i < 128; i++) begin
				dmem[i[6:0]] <= fill_word(i);
			end
			log_addr.delete();
			log_data.delete();
			finished <= 1'b0;
		end else if (rst_n && dmem_write && !dmem_stall && !imem_stall) begin
			dmem[dmem_addr[6:0]] <= byte_reverse(dmem_wdata);
			log_addr.push_back(dmem_byte_addr);
			log_data.push_back(byte_reverse(dmem_wdata));
			// skipped and flushed stores all target the top region
			assert (dmem_byte_addr < bad_base) else begin
				log_errs++;
				$display("ERR %0t: store from a skipped address %h", $time, dmem_byte_addr);
			end
			if (dmem_byte_addr == done_addr) begin
				finished <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// port checks

	always @(posedge clk) begin
		if (prev_rst_low) begin
			assert (!dmem_read && !dmem_write && imem_addr == '0) else begin
				port_errs++;
				$display("ERR %0t: core not idle at reset, imem_addr %h", $time, imem_addr);
			end
		end
		if (rst_n) begin
			assert (!(dmem_read && dmem_write)) else begin
				port_errs++;
				$display("ERR %0t: load and store together at %h", $time, dmem_byte_addr);
			end
		end
		if (prev_hold && rst_n) begin
			assert ({dmem_read, dmem_write, dmem_addr, dmem_wdata} == prev_req) else begin
				port_errs++;
				$display("ERR %0t: request moved under stall, now at %h", $time, dmem_byte_addr);
			end
		end
		prev_rst_low <= !rst_n;
		prev_hold    <= rst_n && (dmem_read || dmem_write) && (imem_stall || dmem_stall);
		prev_req     <= {dmem_read, dmem_write, dmem_addr, dmem_wdata};
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= phase_count * cycles_per_phase) begin
			$display("timeout: program did not finish in phase %0d after %0d cycles", phase, cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ----------------------------------------
	// program and expected stores

	task automatic build_program();
		for (int i = 0; i < 64; i++) begin
			imem[i[5:0]] = '0;
		end
		// dependent arithmetic, results used at once
		place(i_form(opc_imm, 0, 1, 0, 25));
		place(i_form(opc_imm, 0, 2, 0, -7));
		place(r_form(0, 0, 3, 1, 2));
		place(s_form(3, 0, 'h100));
		place(r_form('h20, 0, 4, 3, 1));
		place(r_form(0, 7, 5, 4, 1));
		place(r_form(0, 6, 6, 5, 2));
		place(r_form(0, 2, 7, 2, 1));
		place(s_form(4, 0, 'h104));
		place(s_form(5, 0, 'h108));
		place(s_form(6, 0, 'h10c));
		place(s_form(7, 0, 'h110));
		place(i_form(opc_imm, 7, 8, 6, 'h0f0));
		place(i_form(opc_imm, 6, 9, 8, 'h00a));
		place(i_form(opc_imm, 2, 10, 2, -8));
		place(i_form(opc_imm, 2, 11, 9, 'h100));
		place(r_form(0, 0, 12, 10, 11));
		place(s_form(9, 0, 'h114));
		place(s_form(12, 0, 'h118));
		// load then immediate use
		place(i_form(opc_load, 2, 13, 0, 'h040));
		place(i_form(opc_imm, 0, 14, 13, 'h123));
		place(s_form(14, 0, 'h11c));
		// two taken, two not taken
		place(b_form(0, 10, 0, 8));
		place(s_form(1, 0, 'h1f0));
		place(b_form(1, 11, 0, 8));
		place(s_form(1, 0, 'h1f4));
		place(b_form(0, 1, 2, 8));
		place(s_form(1, 0, 'h120));
		place(b_form(1, 1, 1, 8));
		place(s_form(2, 0, 'h124));
		// jal at 0x78, jalr at 0x8c on a fresh base
		place(j_form(15, 12));
		place(s_form(1, 0, 'h1f8));
		place(s_form(1, 0, 'h1fc));
		place(s_form(15, 0, 'h128));
		place(i_form(opc_imm, 0, 16, 0, 'h0a0));
		place(i_form(opc_jalr, 0, 17, 16, 0));
		for (int k = 0; k < 4; k++) begin
			place(s_form(1, 0, 'h1e0 + 4 * k));
		end
		place(s_form(17, 0, 'h12c));
		place(i_form(opc_imm, 0, 18, 0, 1));
		place(s_form(18, 0, 'h130));
		place(j_form(0, 0));
	endtask

	task automatic build_expected();
		word_t r1, r2, r3, r4, r5, r6, r7, r9, r10, r11;
		r1  = 25;
		r2  = -7;
		r3  = r1 + r2;
		r4  = r3 - r1;
		r5  = r4 & r1;
		r6  = r5 | r2;
		r7  = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
		r9  = (r6 & 32'h0f0) | 32'h00a;
		r10 = ($signed(r2) < -8) ? 32'd1 : 32'd0;
		r11 = ($signed(r9) < 256) ? 32'd1 : 32'd0;
		add_expected('h100, r3);
		add_expected('h104, r4);
		add_expected('h108, r5);
		add_expected('h10c, r6);
		add_expected('h110, r7);
		add_expected('h114, r9);
		add_expected('h118, r10 + r11);
		add_expected('h11c, fill_word('h40 / 4) + 32'h123);
		add_expected('h120, r1);
		add_expected('h124, r2);
		add_expected('h128, 32'h78 + 4);
		add_expected('h12c, 32'h8c + 4);
		add_expected('h130, 1);
	endtask

	// ----------------------------------------
	// phases

	task automatic check_log(input int p);
		assert (log_addr.size() == exp_addr.size()) else begin
			store_errs++;
			$display("ERR %0t: phase %0d logged %0d stores, expected %0d", $time, p,
				log_addr.size(), exp_addr.size());
		end
		for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
			assert (log_addr[i] == exp_addr[i] && log_data[i] == exp_data[i]) else begin
				store_errs++;
				$display("ERR %0t: phase %0d store %0d at %h data %h, expected %h at %h", $time,
					p, i, log_addr[i], log_data[i], exp_data[i], exp_addr[i]);
			end
		end
	endtask

	task automatic run_phase(input int p);
		phase   <= p;
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(posedge clk);
		while (!rst_n) begin
			@(posedge clk);
		end
		while (!finished) begin
			@(posedge clk);
		end
		check_log(p);
	endtask

	initial begin
		build_program();
		build_expected();
		for (int p = 0; p < phase_count; p++) begin
			run_phase(p);
		end
		$display("errors: port %0d, log %0d, store %0d over %0d cycles", port_errs, log_errs,
			store_errs, cycles);
		if (port_errs + log_errs + store_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- flist.f
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_hazard.sv
logic/rv_core.sv
test/tb_clock.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_top -f flist.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
